/* flist.f */
common/clock_pkg.sv
common/count_ctrl_if.sv
rtl/tick_gen.sv
rtl/key_filter.sv
controller/clock_ctrl.sv
timekeep/time_counters.sv
display/seg_scan.sv
rtl/clock_top.sv
tb/tb_clock_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f flist.f --top-module tb_clock_top \
	-Mdir obj_dir -o sim_clock > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_clock > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
fi
exit 1

/* tb/tb_clock_top.sv */
`timescale 1ns/1ps

module tb_clock_top
	import clock_pkg::*;
;

	localparam int SEC_DIV    = 400;
	localparam int SCAN_DIV   = 4;
	localparam int SAMPLE_DIV = 2;
	localparam int MAX_CYCLES = 60_000;
	// One full pass over the six positions
	localparam int SCAN_SLACK = SCAN_DIV * NUM_DIGITS;
	localparam int KEY_MODE   = 0;
	localparam int KEY_POS    = 1;
	localparam int KEY_INC    = 2;
	localparam int KEY_ALARM  = 3;

	logic       clk;
	logic       rst_n;
	logic       i_key_mode_n;
	logic       i_key_pos_n;
	logic       i_key_inc_n;
	logic       i_key_alarm_n;
	logic [5:0] o_seg_enb;
	logic [6:0] o_seg;
	logic       o_seg_dp;
	logic       o_alarm;

	int     cycles;
	int     fail_count;
	mode_t  m_mode;
	pos_t   m_pos;
	logic   m_alarm_en;
	count_t t_min;
	count_t t_sec;
	count_t a_min;
	count_t a_sec;

	clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) clock_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_key_mode_n  (i_key_mode_n),
		.i_key_pos_n   (i_key_pos_n),
		.i_key_inc_n   (i_key_inc_n),
		.i_key_alarm_n (i_key_alarm_n),
		.o_seg_enb     (o_seg_enb),
		.o_seg         (o_seg),
		.o_seg_dp      (o_seg_dp),
		.o_alarm       (o_alarm)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------------
	// Timeout and enable sanity
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles", cycles);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	// Exactly one position lit at any time
	always @(negedge clk) begin
		if (rst_n && $countones(~o_seg_enb) != 1) begin
			$display("position enables at %0t are not one-hot zero: %b", $time, o_seg_enb);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic seg_t digit_pattern(input int d);
		seg_t s;
		case (d)
			0:       s = 7'b1111110;
			1:       s = 7'b0110000;
			2:       s = 7'b1101101;
			3:       s = 7'b1111001;
			4:       s = 7'b0110011;
			5:       s = 7'b1011011;
			6:       s = 7'b1011111;
			7:       s = 7'b1110000;
			8:       s = 7'b1111111;
			9:       s = 7'b1110011;
			default: s = 7'b0000000;
		endcase
		return s;
	endfunction

	// Returns {dp, seg} for one scan position
	function automatic logic [7:0] expect_pos(input int p, input count_t min,
			input count_t sec, input mode_t mode);
		logic [7:0] r;
		r = '0;
		case (p)
			0: r = {mode[0], digit_pattern(sec % 10)};
			1: r = {mode[1], digit_pattern(sec / 10)};
			2: r = {1'b0, digit_pattern(min % 10)};
			3: r = {1'b0, digit_pattern(min / 10)};
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic count_t step60(input count_t v);
		return (v == 6'd59) ? 6'd0 : v + 6'd1;
	endfunction

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic fail_now();
		fail_count++;
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_seg(input string name, input seg_t got, input seg_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_dp(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_alarm(input logic exp);
		if (o_alarm !== exp) begin
			$display("mismatch at %0t: o_alarm is %b, expected %b", $time, o_alarm, exp);
			fail_now();
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			fail_now();
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus and display access
	// ------------------------------------------------------------------------
	task automatic press_key(input int which);
		@(posedge clk);
		#1;
		case (which)
			KEY_MODE: i_key_mode_n  = 1'b0;
			KEY_POS:  i_key_pos_n   = 1'b0;
			KEY_INC:  i_key_inc_n   = 1'b0;
			default:  i_key_alarm_n = 1'b0;
		endcase
		repeat (8) @(posedge clk);
		#1;
		i_key_mode_n  = 1'b1;
		i_key_pos_n   = 1'b1;
		i_key_inc_n   = 1'b1;
		i_key_alarm_n = 1'b1;
		repeat (8) @(posedge clk);
	endtask

	task automatic press_mode();
		press_key(KEY_MODE);
		case (m_mode)
			MODE_CLOCK: m_mode = MODE_SETUP;
			MODE_SETUP: m_mode = MODE_ALARM;
			default:    m_mode = MODE_CLOCK;
		endcase
	endtask

	task automatic press_pos();
		press_key(KEY_POS);
		m_pos = (m_pos == POS_SEC) ? POS_MIN : POS_SEC;
	endtask

	task automatic press_inc();
		press_key(KEY_INC);
		if (m_mode == MODE_SETUP && m_pos == POS_SEC) t_sec = step60(t_sec);
		if (m_mode == MODE_SETUP && m_pos == POS_MIN) t_min = step60(t_min);
		if (m_mode == MODE_ALARM && m_pos == POS_SEC) a_sec = step60(a_sec);
		if (m_mode == MODE_ALARM && m_pos == POS_MIN) a_min = step60(a_min);
	endtask

	task automatic press_alarm();
		press_key(KEY_ALARM);
		m_alarm_en = !m_alarm_en;
	endtask

	// Advances at least one cycle, sampled mid-cycle
	task automatic wait_pos(input int p);
		do begin
			@(negedge clk);
		end while (o_seg_enb !== ~(6'b1 << p));
	endtask

	task automatic check_display(input count_t min, input count_t sec, input mode_t mode);
		logic [7:0] e;
		for (int p = 0; p < NUM_DIGITS; p++) begin
			wait_pos(p);
			e = expect_pos(p, min, sec, mode);
			check_seg("o_seg", o_seg, e[6:0]);
			check_dp("o_seg_dp", o_seg_dp, e[7]);
		end
	endtask

	task automatic read_time(output count_t min, output count_t sec);
		int d[4];
		for (int p = 0; p < 4; p++) begin
			wait_pos(p);
			d[p] = -1;
			for (int k = 0; k < 10; k++) begin
				if (o_seg === digit_pattern(k)) d[p] = k;
			end
			if (d[p] < 0) begin
				$display("position %0d shows no decimal digit at %0t", p, $time);
				fail_now();
			end
		end
		sec = count_t'(d[1] * 10 + d[0]);
		min = count_t'(d[3] * 10 + d[2]);
	endtask

	// Returns the cycle at which the seconds ones digit changed
	task automatic wait_sec_change(output int at_cycle);
		seg_t base;
		wait_pos(0);
		base = o_seg;
		do begin
			wait_pos(0);
		end while (o_seg === base);
		at_cycle = cycles;
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		int n;
		int c_prev;
		int c_now;
		int adv;
		int tgt;
		count_t r_min;
		count_t r_sec;

		void'($urandom(32'hb247));
		clk           = 1'b0;
		rst_n         = 1'b0;
		i_key_mode_n  = 1'b1;
		i_key_pos_n   = 1'b1;
		i_key_inc_n   = 1'b1;
		i_key_alarm_n = 1'b1;
		cycles        = 0;
		fail_count    = 0;
		m_mode        = MODE_CLOCK;
		m_pos         = POS_SEC;
		m_alarm_en    = 1'b0;
		t_min         = '0;
		t_sec         = '0;
		a_min         = '0;
		a_sec         = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// After reset
		check_alarm(1'b0);
		press_key(KEY_INC);
		check_display(6'd0, 6'd0, MODE_CLOCK);

		// Setup mode, time stands still
		press_mode();
		check_display(t_min, t_sec, m_mode);
		// At least one seconds wrap
		n = $urandom % 10 + 60;
		repeat (n) begin
			press_inc();
			check_display(t_min, t_sec, m_mode);
		end
		press_pos();
		n = $urandom % 70 + 1;
		repeat (n) begin
			press_inc();
			check_display(t_min, t_sec, m_mode);
		end
		press_pos();
		while (t_sec != 6'd57) press_inc();
		check_display(t_min, t_sec, m_mode);

		// Through the alarm view back to the running clock
		press_mode();
		check_display(a_min, a_sec, m_mode);
		press_mode();
		wait_sec_change(c_prev);
		read_time(r_min, r_sec);
		check_count("minutes", r_min, t_min);
		if (r_sec != 6'd58 && r_sec != 6'd59) check_count("seconds", r_sec, 6'd58);
		t_sec = r_sec;
		repeat (4) begin
			wait_sec_change(c_now);
			t_min = (t_sec == 6'd59) ? step60(t_min) : t_min;
			t_sec = step60(t_sec);
			if (c_now - c_prev > SEC_DIV + SCAN_SLACK ||
					c_now - c_prev < SEC_DIV - SCAN_SLACK) begin
				$display("seconds step took %0d cycles at %0t", c_now - c_prev, $time);
				fail_now();
			end
			c_prev = c_now;
			check_display(t_min, t_sec, m_mode);
		end

		// Alarm adjust while the time keeps running
		press_mode();
		check_display(t_min, t_sec, m_mode);
		press_mode();
		c_prev = cycles;
		// Enough presses for several seconds to pass
		n = $urandom % 20 + 40;
		repeat (n) press_inc();
		press_pos();
		n = $urandom % 20 + 40;
		repeat (n) press_inc();
		press_pos();
		check_display(a_min, a_sec, m_mode);
		press_mode();
		wait_sec_change(c_now);
		read_time(r_min, r_sec);
		adv = ((r_min * 60 + r_sec) - (t_min * 60 + t_sec) + 3600) % 3600;
		n = (c_now - c_prev) / SEC_DIV;
		if (adv < n - 1 || adv > n + 1) begin
			$display("time moved %0d s over %0d cycles in alarm mode", adv, c_now - c_prev);
			fail_now();
		end
		t_min = r_min;
		t_sec = r_sec;

		// Alarm set a few seconds ahead
		press_mode();
		check_display(t_min, t_sec, m_mode);
		tgt = (t_min * 60 + t_sec + 15) % 3600;
		press_mode();
		while (a_sec != count_t'(tgt % 60)) press_inc();
		press_pos();
		while (a_min != count_t'(tgt / 60)) press_inc();
		press_pos();
		check_display(a_min, a_sec, m_mode);
		press_mode();
		press_alarm();
		@(negedge clk);
		check_alarm(1'b0);

		// Latch on the match, hold past it, release on the key
		do begin
			@(negedge clk);
		end while (o_alarm !== 1'b1);
		read_time(r_min, r_sec);
		check_count("minutes", r_min, a_min);
		check_count("seconds", r_sec, a_sec);
		wait_sec_change(c_now);
		check_alarm(m_alarm_en);
		press_alarm();
		@(negedge clk);
		check_alarm(m_alarm_en);

		if (fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* rtl/clock_top.sv */
`timescale 1ns/1ps

module clock_top
	import clock_pkg::*;
#(
	parameter int SEC_DIV    = 50_000_000,
	parameter int SCAN_DIV   = 10_000,
	parameter int SAMPLE_DIV = 500_000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_key_mode_n,
	input  logic       i_key_pos_n,
	input  logic       i_key_inc_n,
	input  logic       i_key_alarm_n,
	output logic [5:0] o_seg_enb,
	output logic [6:0] o_seg,
	output logic       o_seg_dp,
	output logic       o_alarm
);

	logic   sec_tick;
	logic   scan_tick;
	logic   sample_tick;
	logic   press_mode;
	logic   press_pos;
	logic   press_inc;
	logic   press_alarm;
	mode_t  mode;
	logic   alarm_en;
	count_t disp_min;
	count_t disp_sec;

	count_ctrl_if cc_if ();

	// ------------------------------------------------------------------------
	// Enable ticks
	// ------------------------------------------------------------------------
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	// ------------------------------------------------------------------------
	// Keys
	// ------------------------------------------------------------------------
	key_filter u_key_mode (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_key_n  (i_key_mode_n),
		.o_press  (press_mode)
	);

	key_filter u_key_pos (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_key_n  (i_key_pos_n),
		.o_press  (press_pos)
	);

	key_filter u_key_inc (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_key_n  (i_key_inc_n),
		.o_press  (press_inc)
	);

	key_filter u_key_alarm (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_key_n  (i_key_alarm_n),
		.o_press  (press_alarm)
	);

	// ------------------------------------------------------------------------
	// Control, counting and display
	// ------------------------------------------------------------------------
	clock_ctrl u_clock_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sec_tick    (sec_tick),
		.i_press_mode  (press_mode),
		.i_press_pos   (press_pos),
		.i_press_inc   (press_inc),
		.i_press_alarm (press_alarm),
		.o_mode        (mode),
		.o_alarm_en    (alarm_en),
		.ctl           (cc_if.ctrl)
	);

	time_counters u_time_counters (
		.clk        (clk),
		.rst_n      (rst_n),
		.cc         (cc_if.cnt),
		.i_alarm_en (alarm_en),
		.o_disp_min (disp_min),
		.o_disp_sec (disp_sec),
		.o_alarm    (o_alarm)
	);

	seg_scan u_seg_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_min       (disp_min),
		.i_sec       (disp_sec),
		.i_mode      (mode),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

/* display/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan
	import clock_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      i_scan_tick,
	input  count_t    i_min,
	input  count_t    i_sec,
	input  mode_t     i_mode,
	output seg_t      o_seg,
	output logic      o_seg_dp,
	output enb_t      o_seg_enb
);

	localparam scan_idx_t IDX_LAST = scan_idx_t'(NUM_DIGITS - 1);

	scan_idx_t scan_idx;
	scan_idx_t idx_next;
	digit_t    sec_tens;
	digit_t    sec_ones;
	digit_t    min_tens;
	digit_t    min_ones;
	seg_t      seg_next;
	logic      dp_next;

	// ------------------------------------------------------------------------
	// Digit split
	// ------------------------------------------------------------------------
	assign sec_tens = digit_t'(i_sec / 6'd10);
	assign sec_ones = digit_t'(i_sec % 6'd10);
	assign min_tens = digit_t'(i_min / 6'd10);
	assign min_ones = digit_t'(i_min % 6'd10);

	// ------------------------------------------------------------------------
	// Scan position
	// ------------------------------------------------------------------------
	always_comb begin
		idx_next = scan_idx;
		if (i_scan_tick) begin
			idx_next = (scan_idx == IDX_LAST) ? '0 : scan_idx + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else begin
			scan_idx <= idx_next;
		end
	end

	// Segment and dot for the position about to be shown
	always_comb begin
		seg_next = '0;
		dp_next  = 1'b0;
		case (idx_next)
			3'd0: begin
				seg_next = seg_of_digit(sec_ones);
				dp_next  = i_mode[0];
			end
			3'd1: begin
				seg_next = seg_of_digit(sec_tens);
				dp_next  = i_mode[1];
			end
			3'd2:    seg_next = seg_of_digit(min_ones);
			3'd3:    seg_next = seg_of_digit(min_tens);
			// Positions 4 and 5 stay dark
			default: seg_next = '0;
		endcase
	end

	// Outputs move together with the index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= seg_of_digit(4'd0);
			o_seg_dp  <= 1'b0;
			o_seg_enb <= 6'b111110;
		end else begin
			o_seg     <= seg_next;
			o_seg_dp  <= dp_next;
			o_seg_enb <= ~(enb_t'(1) << idx_next);
		end
	end

endmodule

/* timekeep/time_counters.sv */
`timescale 1ns/1ps

module time_counters
	import clock_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	count_ctrl_if.cnt cc,
	input  logic   i_alarm_en,
	output count_t o_disp_min,
	output count_t o_disp_sec,
	output logic   o_alarm
);

	count_t sec;
	count_t min;
	count_t alm_sec;
	count_t alm_min;
	logic   sec_wrap;
	logic   min_step;
	logic   alarm_hit;

	// Modulo-60 step
	function automatic count_t wrap_inc(input count_t value);
		count_t next;
		if (value >= COUNT_MAX) begin
			next = '0;
		end else begin
			next = value + 1'b1;
		end
		return next;
	endfunction

	// ------------------------------------------------------------------------
	// Time of day
	// ------------------------------------------------------------------------
	assign sec_wrap = cc.sec_inc && (sec == COUNT_MAX);

	// Carry only while the clock is running
	assign min_step = cc.min_inc || (sec_wrap && cc.carry_en);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec <= '0;
		end else if (cc.sec_inc) begin
			sec <= wrap_inc(sec);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			min <= '0;
		end else if (min_step) begin
			min <= wrap_inc(min);
		end
	end

	// ------------------------------------------------------------------------
	// Alarm time
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alm_sec <= '0;
		end else if (cc.alm_sec_inc) begin
			alm_sec <= wrap_inc(alm_sec);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alm_min <= '0;
		end else if (cc.alm_min_inc) begin
			alm_min <= wrap_inc(alm_min);
		end
	end

	assign alarm_hit = (sec == alm_sec) && (min == alm_min);

	// Latched on a match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (alarm_hit || o_alarm);
		end
	end

	// Display source
	assign o_disp_sec = cc.show_alarm ? alm_sec : sec;
	assign o_disp_min = cc.show_alarm ? alm_min : min;

endmodule

/* controller/clock_ctrl.sv */
`timescale 1ns/1ps

module clock_ctrl
	import clock_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_sec_tick,
	input  logic   i_press_mode,
	input  logic   i_press_pos,
	input  logic   i_press_inc,
	input  logic   i_press_alarm,
	output mode_t  o_mode,
	output logic   o_alarm_en,
	count_ctrl_if.ctrl ctl
);

	pos_t pos;

	// ------------------------------------------------------------------------
	// Mode FSM, field position and alarm enable
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
		end else if (i_press_mode) begin
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos <= POS_SEC;
		end else if (i_press_pos) begin
			pos <= (pos == POS_SEC) ? POS_MIN : POS_SEC;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_en <= 1'b0;
		end else if (i_press_alarm) begin
			o_alarm_en <= !o_alarm_en;
		end
	end

	// ------------------------------------------------------------------------
	// Increment steering
	// ------------------------------------------------------------------------
	always_comb begin
		ctl.sec_inc     = 1'b0;
		ctl.min_inc     = 1'b0;
		ctl.alm_sec_inc = 1'b0;
		ctl.alm_min_inc = 1'b0;
		ctl.carry_en    = 1'b0;
		case (o_mode)
			MODE_CLOCK: begin
				ctl.sec_inc  = i_sec_tick;
				ctl.carry_en = 1'b1;
			end
			MODE_SETUP: begin
				// Time stands still, key sets the chosen field
				ctl.sec_inc = i_press_inc && (pos == POS_SEC);
				ctl.min_inc = i_press_inc && (pos == POS_MIN);
			end
			MODE_ALARM: begin
				// Clock keeps running behind the alarm view
				ctl.sec_inc     = i_sec_tick;
				ctl.carry_en    = 1'b1;
				ctl.alm_sec_inc = i_press_inc && (pos == POS_SEC);
				ctl.alm_min_inc = i_press_inc && (pos == POS_MIN);
			end
			default: begin
				ctl.carry_en = 1'b0;
			end
		endcase
	end

	assign ctl.show_alarm = (o_mode == MODE_ALARM);

endmodule

/* rtl/key_filter.sv */
`timescale 1ns/1ps

// Slow-sampled key with a press pulse on the high-to-low edge
module key_filter (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_key_n,
	output logic o_press
);

	logic key_cur;
	logic key_prev;

	// Two sample stages, both start as released
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key_cur  <= 1'b1;
			key_prev <= 1'b1;
		end else if (i_sample) begin
			key_cur  <= i_key_n;
			key_prev <= key_cur;
		end
	end

	// Edge is judged on the stages as the tick finds them
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= 1'b0;
		end else begin
			o_press <= i_sample && !key_cur && key_prev;
		end
	end

endmodule

/* rtl/tick_gen.sv */
`timescale 1ns/1ps

// One-cycle enable pulse every DIV clocks
module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	// Pulse lands in the cycle after the counter reaches its last value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CNT_LAST) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

/* common/count_ctrl_if.sv */
`timescale 1ns/1ps

// Increment and carry steering from the controller to the time counters
interface count_ctrl_if;

	// One-cycle increment pulses
	logic sec_inc;
	logic min_inc;
	logic alm_sec_inc;
	logic alm_min_inc;

	// Levels
	logic carry_en;
	logic show_alarm;

	modport ctrl (
		output sec_inc,
		output min_inc,
		output alm_sec_inc,
		output alm_min_inc,
		output carry_en,
		output show_alarm
	);

	modport cnt (
		input  sec_inc,
		input  min_inc,
		input  alm_sec_inc,
		input  alm_min_inc,
		input  carry_en,
		input  show_alarm
	);

endinterface

/* common/clock_pkg.sv */
package clock_pkg;

	// ------------------------------------------------------------------------
	// Operating modes and the field adjusted by the increment key
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic {
		POS_SEC = 1'b0,
		POS_MIN = 1'b1
	} pos_t;

	// ------------------------------------------------------------------------
	// Value widths
	// ------------------------------------------------------------------------
	// Seconds or minutes, 0 to 59
	typedef logic [5:0] count_t;

	// One decimal digit
	typedef logic [3:0] digit_t;

	// Segments {a,b,c,d,e,f,g}, 1 lights the segment
	typedef logic [6:0] seg_t;

	// Position enables, active low
	typedef logic [5:0] enb_t;

	// Scan position 0 to 5
	typedef logic [2:0] scan_idx_t;

	localparam count_t COUNT_MAX = 6'd59;
	localparam int NUM_DIGITS = 6;

	// Standard seven-segment patterns, blank for anything above 9
	function automatic seg_t seg_of_digit(input digit_t digit);
		seg_t seg;
		case (digit)
			4'd0:    seg = 7'b111_1110;
			4'd1:    seg = 7'b011_0000;
			4'd2:    seg = 7'b110_1101;
			4'd3:    seg = 7'b111_1001;
			4'd4:    seg = 7'b011_0011;
			4'd5:    seg = 7'b101_1011;
			4'd6:    seg = 7'b101_1111;
			4'd7:    seg = 7'b111_0000;
			4'd8:    seg = 7'b111_1111;
			4'd9:    seg = 7'b111_0011;
			default: seg = 7'b000_0000;
		endcase
		return seg;
	endfunction

endpackage
